//--- cassette_control.sv
// Cassette control: load tracking, play and rewind levels, tape source select
`default_nettype none

module cassette_control (
   input  wire                              clock_bus,
   input  wire                              rst_n,
   input  wire                              ioctl_download,
   input  host_status_pkg::download_index_t ioctl_index,
   input  wire                              motor,
   input  wire                              cas_dout,
   input  wire                              tape_adc,
   input  wire                              tape_adc_act,
   input  wire                              rewind_req,
   input  wire                              tape_adc_sel,
   input  wire                              core_reset,
   output logic                             play,
   output logic                             rewind,
   output logic                             tape_in
);

   logic is_cas;
   logic is_cas_last;
   logic cas_load;

   assign is_cas = ioctl_download & (ioctl_index[5:0] == host_status_pkg::cas_index);

   // ====================
   // Load tracking
   // ====================
   // Set on the end of a CAS download, kept until board reset
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         is_cas_last <= 1'b0;
         cas_load    <= 1'b0;
      end else begin
         is_cas_last <= is_cas;
         if (is_cas_last & ~is_cas) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Motor line from the machine is active low
   assign play = ~motor & cas_load;

   // Rewind while a new file streams in or the core is held in reset
   assign rewind = rewind_req | is_cas | core_reset;

   // ADC input only counts while the front end reports a signal
   assign tape_in = tape_adc_sel ? (tape_adc_act & tape_adc) : cas_dout;

endmodule

`default_nettype wire

//--- host_status_pkg.sv
// Host status package: status word layout, menu mask bits and board constants
`default_nettype none

package host_status_pkg;

   // ====================
   // Host-side widths
   // ====================
   typedef logic [63:0] status_word_t;
   typedef logic [15:0] menu_mask_t;
   typedef logic [31:0] img_size_t;
   typedef logic [15:0] download_index_t;

   // Status word bit positions
   localparam int st_reset_bit       = 0;
   localparam int st_rewind_bit      = 9;
   localparam int st_detach_bit      = 10;
   localparam int st_mount_reset_bit = 12;
   localparam int st_reset_close_bit = 21;
   localparam int st_sram_save_bit   = 38;
   localparam int st_sram_load_bit   = 39;
   localparam int st_tape_adc_bit    = 40;

   // Menu mask layout, a set bit hides the entry
   localparam int mm_fdc_bit    = 0;
   localparam int mm_slot_a_bit = 1;
   localparam int mm_slot_b_bit = 2;
   localparam int mm_ocm_bit    = 3;
   localparam int mm_sram_bit   = 6;
   localparam int mm_tape_bit   = 7;

   // ====================
   // Image slots
   // ====================
   localparam int vsd_slot      = 4;
   localparam int num_img_slots = 6;

   // Cassette downloads, matched on the low index bits only
   localparam logic [5:0] cas_index = 6'd5;

   // SD LED hold time in clock cycles
   localparam logic [31:0] sd_act_hold_default = 32'd1_000_000;

endpackage

`default_nettype wire

//--- mem_bus_pkg.sv
// Memory bus package: DDR3 and SDRAM widths and request structs
`default_nettype none

package mem_bus_pkg;

   typedef logic [27:0] ddr_addr_t;
   typedef logic [26:0] sdram_addr_t;
   typedef logic [7:0]  mem_byte_t;

   // DDR3 buffer read port
   typedef struct packed {
      ddr_addr_t addr;
      logic      rd;
   } ddr_rd_req_t;

   // SDRAM channel 1, rnw high for a read
   typedef struct packed {
      sdram_addr_t addr;
      mem_byte_t   din;
      logic        req;
      logic        rnw;
   } sdram_req_t;

   // Value seen by the CPU when nothing drives the bus
   localparam mem_byte_t open_bus_byte = 8'hFF;

endpackage

`default_nettype wire

//--- memory_port_select.sv
// Memory port select: owners of the DDR3 read port and SDRAM channel 1
`default_nettype none

module memory_port_select (
   input  wire                      loader_busy,
   input  mem_bus_pkg::ddr_rd_req_t loader_rd,
   input  mem_bus_pkg::ddr_rd_req_t cas_rd,
   input  wire                      upload,
   input  mem_bus_pkg::sdram_req_t  upload_req,
   input  mem_bus_pkg::sdram_req_t  cpu_req,
   input  mem_bus_pkg::mem_byte_t   sdram_dout,
   output mem_bus_pkg::ddr_rd_req_t ddr_rd,
   output mem_bus_pkg::sdram_req_t  sdram_ch1,
   output mem_bus_pkg::mem_byte_t   ram_dout
);

   // ====================
   // DDR3 read port
   // ====================
   // Loader has priority, the tape player reads in its idle time
   assign ddr_rd = loader_busy ? loader_rd : cas_rd;

   // ====================
   // SDRAM channel 1
   // ====================
   always_comb begin
      if (upload) begin
         sdram_ch1     = upload_req;
         // Upload only ever writes
         sdram_ch1.rnw = 1'b0;
      end else begin
         sdram_ch1 = cpu_req;
      end
   end

   // Reads outside the SDRAM see an open bus
   assign ram_dout = cpu_req.req ? sdram_dout : mem_bus_pkg::open_bus_byte;

endmodule

`default_nettype wire

//--- msx_glue_top.sv
// MSX board glue top: status decode, SD routing, cassette and memory owners
`default_nettype none

module msx_glue_top #(
   parameter logic [31:0] act_hold_cycles = host_status_pkg::sd_act_hold_default
) (
   input  wire                                          clock_bus,
   input  wire                                          rst_n,
   // Host status and menu
   input  host_status_pkg::status_word_t                status,
   input  wire                                          reset_req,
   input  wire                                          upload_reset,
   input  wire [host_status_pkg::num_img_slots-1:0]     img_mounted,
   input  host_status_pkg::img_size_t                   img_size,
   input  wire                                          fdc_enable,
   input  wire                                          ocm_boot,
   input  wire                                          sram_present,
   input  wire                                          load_sram,
   output logic                                         hard_reset,
   output logic                                         core_reset,
   output host_status_pkg::menu_mask_t                  menu_mask,
   output logic                                         sram_load_req,
   // SD card
   input  wire                                          sd_sclk,
   input  wire                                          sd_mosi_core,
   input  wire                                          card_miso,
   input  wire                                          vsd_miso,
   output logic                                         sd_cs,
   output logic                                         sd_sck,
   output logic                                         sd_mosi,
   output logic                                         sd_miso_core,
   output logic                                         led_user,
   output logic [1:0]                                   led_disk,
   // Cassette
   input  wire                                          ioctl_download,
   input  host_status_pkg::download_index_t             ioctl_index,
   input  wire                                          motor,
   input  wire                                          cas_dout,
   input  wire                                          tape_adc,
   input  wire                                          tape_adc_act,
   output logic                                         play,
   output logic                                         rewind,
   output logic                                         tape_in,
   // Memory ports
   input  wire                                          loader_busy,
   input  mem_bus_pkg::ddr_rd_req_t                     loader_rd,
   input  mem_bus_pkg::ddr_rd_req_t                     cas_rd,
   input  wire                                          upload,
   input  mem_bus_pkg::sdram_req_t                      upload_req,
   input  mem_bus_pkg::sdram_req_t                      cpu_req,
   input  mem_bus_pkg::mem_byte_t                       sdram_dout,
   output mem_bus_pkg::ddr_rd_req_t                     ddr_rd,
   output mem_bus_pkg::sdram_req_t                      sdram_ch1,
   output mem_bus_pkg::mem_byte_t                       ram_dout
);

   logic mount_pulse;
   logic rewind_req;
   logic tape_adc_sel;

   // ====================
   // Status bit taps
   // ====================
   assign mount_pulse  = img_mounted[host_status_pkg::vsd_slot];
   assign rewind_req   = status[host_status_pkg::st_rewind_bit];
   assign tape_adc_sel = status[host_status_pkg::st_tape_adc_bit];

   status_decode u_status_decode (
      .clock_bus     (clock_bus),
      .rst_n         (rst_n),
      .status        (status),
      .reset_req     (reset_req),
      .upload_reset  (upload_reset),
      .mount_pulse   (mount_pulse),
      .fdc_enable    (fdc_enable),
      .ocm_boot      (ocm_boot),
      .sram_present  (sram_present),
      .load_sram     (load_sram),
      .hard_reset    (hard_reset),
      .core_reset    (core_reset),
      .menu_mask     (menu_mask),
      .sram_load_req (sram_load_req)
   );

   sd_route #(
      .act_hold_cycles (act_hold_cycles)
   ) u_sd_route (
      .clock_bus    (clock_bus),
      .rst_n        (rst_n),
      .mount_pulse  (mount_pulse),
      .img_size     (img_size),
      .sd_sclk      (sd_sclk),
      .sd_mosi_core (sd_mosi_core),
      .card_miso    (card_miso),
      .vsd_miso     (vsd_miso),
      .sd_cs        (sd_cs),
      .sd_sck       (sd_sck),
      .sd_mosi      (sd_mosi),
      .sd_miso_core (sd_miso_core),
      .led_user     (led_user),
      .led_disk     (led_disk)
   );

   cassette_control u_cassette_control (
      .clock_bus      (clock_bus),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .motor          (motor),
      .cas_dout       (cas_dout),
      .tape_adc       (tape_adc),
      .tape_adc_act   (tape_adc_act),
      .rewind_req     (rewind_req),
      .tape_adc_sel   (tape_adc_sel),
      .core_reset     (core_reset),
      .play           (play),
      .rewind         (rewind),
      .tape_in        (tape_in)
   );

   memory_port_select u_memory_port_select (
      .loader_busy (loader_busy),
      .loader_rd   (loader_rd),
      .cas_rd      (cas_rd),
      .upload      (upload),
      .upload_req  (upload_req),
      .cpu_req     (cpu_req),
      .sdram_dout  (sdram_dout),
      .ddr_rd      (ddr_rd),
      .sdram_ch1   (sdram_ch1),
      .ram_dout    (ram_dout)
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the MSX glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sources.f \
   --top-module tb_msx_glue -Mdir obj_dir -o tb_msx_glue
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_msx_glue > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
   exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- sd_route.sv
// SD router: virtual or physical card select, pin gating and activity LEDs
`default_nettype none

module sd_route #(
   parameter logic [31:0] act_hold_cycles = host_status_pkg::sd_act_hold_default
) (
   input  wire                          clock_bus,
   input  wire                          rst_n,
   input  wire                          mount_pulse,
   input  host_status_pkg::img_size_t   img_size,
   input  wire                          sd_sclk,
   input  wire                          sd_mosi_core,
   input  wire                          card_miso,
   input  wire                          vsd_miso,
   output logic                         sd_cs,
   output logic                         sd_sck,
   output logic                         sd_mosi,
   output logic                         sd_miso_core,
   output logic                         led_user,
   output logic [1:0]                   led_disk
);

   logic        vsd_sel;
   logic        old_mosi;
   logic        old_miso;
   logic        sd_act;
   logic [31:0] act_cnt;
   logic        line_change;

   // ====================
   // Card select
   // ====================
   // An empty image releases the physical card again
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         vsd_sel <= 1'b0;
      end else if (mount_pulse) begin
         vsd_sel <= |img_size;
      end
   end

   // Physical card is deselected and quiet while the image is in use
   assign sd_cs        = vsd_sel;
   assign sd_sck       = sd_sclk & ~vsd_sel;
   assign sd_mosi      = sd_mosi_core & ~vsd_sel;
   assign sd_miso_core = vsd_sel ? vsd_miso : card_miso;

   // ====================
   // Activity indicator
   // ====================
   assign line_change = (old_mosi ^ sd_mosi_core) | (old_miso ^ sd_miso_core);

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         old_mosi <= 1'b0;
         old_miso <= 1'b0;
         sd_act   <= 1'b0;
         act_cnt  <= act_hold_cycles;
      end else begin
         old_mosi <= sd_mosi_core;
         old_miso <= sd_miso_core;
         sd_act   <= act_cnt < act_hold_cycles;
         if (act_cnt < act_hold_cycles) begin
            act_cnt <= act_cnt + 32'd1;
         end
         // Any edge on the data lines restarts the hold
         if (line_change) begin
            act_cnt <= '0;
         end
      end
   end

   // User LED shows image traffic, disk LED shows card traffic
   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

`default_nettype wire

//--- sources.f
host_status_pkg.sv
mem_bus_pkg.sv
status_decode.sv
sd_route.sv
cassette_control.sv
memory_port_select.sv
msx_glue_top.sv
tb_checker.sv
tb_msx_glue.sv

//--- status_decode.sv
// Status decoder: registers resets, menu mask and save-RAM load request
`default_nettype none

module status_decode (
   input  wire                           clock_bus,
   input  wire                           rst_n,
   input  host_status_pkg::status_word_t status,
   input  wire                           reset_req,
   input  wire                           upload_reset,
   input  wire                           mount_pulse,
   input  wire                           fdc_enable,
   input  wire                           ocm_boot,
   input  wire                           sram_present,
   input  wire                           load_sram,
   output logic                          hard_reset,
   output logic                          core_reset,
   output host_status_pkg::menu_mask_t   menu_mask,
   output logic                          sram_load_req
);

   logic                        hard_d;
   logic                        core_d;
   logic                        mount_reset;
   host_status_pkg::menu_mask_t mask_d;

   // ====================
   // Reset sources
   // ====================
   assign hard_d = reset_req | upload_reset | status[host_status_pkg::st_reset_bit];

   // Reset after mount only applies with the FDC present
   assign mount_reset = status[host_status_pkg::st_mount_reset_bit] & mount_pulse & fdc_enable;

   assign core_d = hard_d
                 | status[host_status_pkg::st_detach_bit]
                 | status[host_status_pkg::st_reset_close_bit]
                 | mount_reset;

   // ====================
   // Menu mask
   // ====================
   always_comb begin
      mask_d = '0;
      mask_d[host_status_pkg::mm_fdc_bit]    = fdc_enable;
      mask_d[host_status_pkg::mm_slot_a_bit] = ocm_boot;
      mask_d[host_status_pkg::mm_slot_b_bit] = ocm_boot;
      mask_d[host_status_pkg::mm_ocm_bit]    = ocm_boot;
      // No SRAM in the machine, hide save and load
      mask_d[host_status_pkg::mm_sram_bit]   = ~sram_present;
      mask_d[host_status_pkg::mm_tape_bit]   = status[host_status_pkg::st_tape_adc_bit];
   end

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         hard_reset    <= 1'b1;
         core_reset    <= 1'b1;
         menu_mask     <= '0;
         sram_load_req <= 1'b0;
      end else begin
         hard_reset    <= hard_d;
         core_reset    <= core_d;
         menu_mask     <= mask_d;
         sram_load_req <= status[host_status_pkg::st_sram_load_bit] | load_sram;
      end
   end

endmodule

`default_nettype wire

//--- tb_checker.sv
// MSX glue checker comparing a cycle model of the glue logic with the DUT ports
`default_nettype none

module tb_checker #(
   parameter logic [31:0] act_hold = 32'd40
) (
   input  wire                                      clock_bus,
   input  wire                                      rst_n,
   input  host_status_pkg::status_word_t            status,
   input  wire                                      reset_req,
   input  wire                                      upload_reset,
   input  wire                                      fdc_enable,
   input  wire                                      ocm_boot,
   input  wire                                      sram_present,
   input  wire                                      load_sram,
   input  wire [host_status_pkg::num_img_slots-1:0] img_mounted,
   input  host_status_pkg::img_size_t               img_size,
   input  wire                                      hard_reset,
   input  wire                                      core_reset,
   input  wire                                      sram_load_req,
   input  host_status_pkg::menu_mask_t              menu_mask,
   input  wire                                      sd_sclk,
   input  wire                                      sd_mosi_core,
   input  wire                                      card_miso,
   input  wire                                      vsd_miso,
   input  wire                                      sd_cs,
   input  wire                                      sd_sck,
   input  wire                                      sd_mosi,
   input  wire                                      sd_miso_core,
   input  wire                                      led_user,
   input  wire [1:0]                                led_disk,
   input  wire                                      ioctl_download,
   input  wire                                      motor,
   input  wire                                      cas_dout,
   input  host_status_pkg::download_index_t         ioctl_index,
   input  wire                                      tape_adc,
   input  wire                                      tape_adc_act,
   input  wire                                      play,
   input  wire                                      rewind,
   input  wire                                      tape_in,
   input  wire                                      loader_busy,
   input  wire                                      upload,
   input  mem_bus_pkg::ddr_rd_req_t                 loader_rd,
   input  mem_bus_pkg::ddr_rd_req_t                 cas_rd,
   input  mem_bus_pkg::ddr_rd_req_t                 ddr_rd,
   input  mem_bus_pkg::sdram_req_t                  upload_req,
   input  mem_bus_pkg::sdram_req_t                  cpu_req,
   input  mem_bus_pkg::sdram_req_t                  sdram_ch1,
   input  mem_bus_pkg::mem_byte_t                   sdram_dout,
   input  mem_bus_pkg::mem_byte_t                   ram_dout,
   output int                                       error_count,
   output int                                       check_count
);
   timeunit 1ns;
   timeprecision 100ps;

   int          errors = 0;
   int          checks = 0;

   // Model of each DUT register as it stands after the last edge
   logic        m_hard;
   logic        m_core;
   logic [15:0] m_mask;
   logic        m_sram_load;
   logic        m_vsd_sel;
   logic        m_old_mosi;
   logic        m_old_miso;
   logic        m_sd_act;
   logic [31:0] m_act_cnt;
   logic        m_is_cas_last;
   logic        m_cas_load;

   assign error_count = errors;
   assign check_count = checks;

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at %0d ns: %s expected %0h, actual %0h",
                  $time, name, expected, actual);
      end
   endtask

   // Cassette downloads use index 5 in the low six bits
   function automatic logic cas_active();
      return ioctl_download & (ioctl_index[5:0] == 6'd5);
   endfunction

   task automatic reset_model();
      m_hard        = 1'b1;
      m_core        = 1'b1;
      m_mask        = '0;
      m_sram_load   = 1'b0;
      m_vsd_sel     = 1'b0;
      m_old_mosi    = 1'b0;
      m_old_miso    = 1'b0;
      m_sd_act      = 1'b0;
      m_act_cnt     = act_hold;
      m_is_cas_last = 1'b0;
      m_cas_load    = 1'b0;
   endtask

   // ====================
   // Output comparison
   // ====================
   task automatic check_outputs();
      mem_bus_pkg::sdram_req_t exp_ch1;
      logic                    exp_tape;
      exp_ch1 = upload ? upload_req : cpu_req;
      if (upload) begin
         exp_ch1.rnw = 1'b0;
      end
      exp_tape = status[host_status_pkg::st_tape_adc_bit] ? (tape_adc_act & tape_adc) : cas_dout;
      compare("hard_reset", 64'(m_hard), 64'(hard_reset));
      compare("core_reset", 64'(m_core), 64'(core_reset));
      compare("menu_mask", 64'(m_mask), 64'(menu_mask));
      compare("sram_load_req", 64'(m_sram_load), 64'(sram_load_req));
      compare("sd_cs", 64'(m_vsd_sel), 64'(sd_cs));
      compare("sd_sck", 64'(m_vsd_sel ? 1'b0 : sd_sclk), 64'(sd_sck));
      compare("sd_mosi", 64'(m_vsd_sel ? 1'b0 : sd_mosi_core), 64'(sd_mosi));
      compare("sd_miso_core", 64'(m_vsd_sel ? vsd_miso : card_miso), 64'(sd_miso_core));
      compare("led_user", 64'(m_vsd_sel & m_sd_act), 64'(led_user));
      compare("led_disk", 64'({1'b1, ~m_vsd_sel & m_sd_act}), 64'(led_disk));
      compare("play", 64'(~motor & m_cas_load), 64'(play));
      compare("rewind", 64'(status[host_status_pkg::st_rewind_bit] | cas_active() | m_core),
              64'(rewind));
      compare("tape_in", 64'(exp_tape), 64'(tape_in));
      compare("ddr_rd", 64'(loader_busy ? loader_rd : cas_rd), 64'(ddr_rd));
      compare("sdram_ch1", 64'(exp_ch1), 64'(sdram_ch1));
      compare("ram_dout", 64'(cpu_req.req ? sdram_dout : 8'hFF), 64'(ram_dout));
   endtask

   // ====================
   // Next state
   // ====================
   task automatic advance_model();
      logic miso_now;
      logic change;
      logic hard_next;
      miso_now  = m_vsd_sel ? vsd_miso : card_miso;
      change    = (m_old_mosi ^ sd_mosi_core) | (m_old_miso ^ miso_now);
      hard_next = reset_req | upload_reset | status[host_status_pkg::st_reset_bit];
      m_core = hard_next
             | status[host_status_pkg::st_detach_bit]
             | status[host_status_pkg::st_reset_close_bit]
             | (status[host_status_pkg::st_mount_reset_bit]
                & img_mounted[host_status_pkg::vsd_slot] & fdc_enable);
      m_hard = hard_next;
      // FDC in bit 0, OCM boot in bits 1 to 3, SRAM in bit 6, tape ADC in bit 7
      m_mask      = '0;
      m_mask[0]   = fdc_enable;
      m_mask[3:1] = {3{ocm_boot}};
      m_mask[6]   = ~sram_present;
      m_mask[7]   = status[host_status_pkg::st_tape_adc_bit];
      m_sram_load = status[host_status_pkg::st_sram_load_bit] | load_sram;
      if (img_mounted[host_status_pkg::vsd_slot]) begin
         m_vsd_sel = |img_size;
      end
      m_sd_act = (m_act_cnt < act_hold);
      if (change) begin
         m_act_cnt = '0;
      end else if (m_act_cnt < act_hold) begin
         m_act_cnt = m_act_cnt + 32'd1;
      end
      m_old_mosi    = sd_mosi_core;
      m_old_miso    = miso_now;
      m_cas_load    = m_cas_load | (m_is_cas_last & ~cas_active());
      m_is_cas_last = cas_active();
   endtask

   // Sampled on the falling edge between input updates
   always @(negedge clock_bus) begin
      if (rst_n === 1'b0) begin
         reset_model();
         check_outputs();
      end else if (rst_n === 1'b1) begin
         check_outputs();
         advance_model();
      end
   end

endmodule

`default_nettype wire

//--- tb_msx_glue.sv
// MSX glue testbench: clock, reset, LFSR stimulus, watchdog and DUT instance
`default_nettype none

module tb_msx_glue;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          clk_period    = 4;
   localparam int          reset_cycles  = 16;
   localparam int          num_cycles    = 4000;
   localparam int          phase_len     = 500;
   localparam int          margin_cycles = 100;
   localparam logic [31:0] act_hold      = 32'd40;

   logic                                      clock_bus;
   logic                                      rst_n;
   host_status_pkg::status_word_t             status;
   logic                                      reset_req;
   logic                                      upload_reset;
   logic [host_status_pkg::num_img_slots-1:0] img_mounted;
   host_status_pkg::img_size_t                img_size;
   logic                                      fdc_enable;
   logic                                      ocm_boot;
   logic                                      sram_present;
   logic                                      load_sram;
   logic                                      hard_reset;
   logic                                      core_reset;
   host_status_pkg::menu_mask_t               menu_mask;
   logic                                      sram_load_req;
   logic                                      sd_sclk;
   logic                                      sd_mosi_core;
   logic                                      card_miso;
   logic                                      vsd_miso;
   logic                                      sd_cs;
   logic                                      sd_sck;
   logic                                      sd_mosi;
   logic                                      sd_miso_core;
   logic                                      led_user;
   logic [1:0]                                led_disk;
   logic                                      ioctl_download;
   host_status_pkg::download_index_t          ioctl_index;
   logic                                      motor;
   logic                                      cas_dout;
   logic                                      tape_adc;
   logic                                      tape_adc_act;
   logic                                      play;
   logic                                      rewind;
   logic                                      tape_in;
   logic                                      loader_busy;
   mem_bus_pkg::ddr_rd_req_t                  loader_rd;
   mem_bus_pkg::ddr_rd_req_t                  cas_rd;
   logic                                      upload;
   mem_bus_pkg::sdram_req_t                   upload_req;
   mem_bus_pkg::sdram_req_t                   cpu_req;
   mem_bus_pkg::mem_byte_t                    sdram_dout;
   mem_bus_pkg::ddr_rd_req_t                  ddr_rd;
   mem_bus_pkg::sdram_req_t                   sdram_ch1;
   mem_bus_pkg::mem_byte_t                    ram_dout;
   int                                        error_count;
   int                                        check_count;
   logic [31:0]                               lfsr = 32'h4eb9;

   msx_glue_top #(.act_hold_cycles(act_hold)) DUT (.*);

   tb_checker #(.act_hold(act_hold)) u_checker (.*);

   initial begin
      clock_bus = 1'b0;
      forever #(clk_period / 2) clock_bus = ~clock_bus;
   end

   // ====================
   // Random source
   // ====================
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   task automatic rand_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[62:0], lfsr[0]};
      end
   endtask

   task automatic init_inputs();
      rst_n          <= 1'b0;
      status         <= '0;
      reset_req      <= 1'b0;
      upload_reset   <= 1'b0;
      img_mounted    <= '0;
      img_size       <= '0;
      fdc_enable     <= 1'b0;
      ocm_boot       <= 1'b0;
      sram_present   <= 1'b1;
      load_sram      <= 1'b0;
      sd_sclk        <= 1'b0;
      sd_mosi_core   <= 1'b0;
      card_miso      <= 1'b0;
      vsd_miso       <= 1'b0;
      ioctl_download <= 1'b0;
      ioctl_index    <= '0;
      motor          <= 1'b1;
      cas_dout       <= 1'b0;
      tape_adc       <= 1'b0;
      tape_adc_act   <= 1'b0;
      loader_busy    <= 1'b0;
      loader_rd      <= '0;
      cas_rd         <= '0;
      upload         <= 1'b0;
      upload_req     <= '0;
      cpu_req        <= '0;
      sdram_dout     <= '0;
   endtask

   // ====================
   // Stimulus
   // ====================
   // Phase 0 mounts, phase 1 downloads, phase 2 busy SD lines, phase 3 quiet
   task automatic drive_cycle(input int phase);
      logic [63:0]                   r;
      logic [63:0]                   m;
      host_status_pkg::status_word_t st;
      logic                          mnt;
      rand_bits(64, r);
      rand_bits(24, m);
      // Reset causes kept rare so the other paths get exercised
      st = r;
      st[host_status_pkg::st_reset_bit]       = (m[3:0] == 4'd0);
      st[host_status_pkg::st_detach_bit]      = (m[7:4] == 4'd0);
      st[host_status_pkg::st_reset_close_bit] = (m[11:8] == 4'd0);
      status       <= st;
      reset_req    <= (m[15:12] == 4'd0);
      upload_reset <= (m[19:16] == 4'd0);
      fdc_enable   <= m[20];
      ocm_boot     <= m[21];
      sram_present <= m[22];
      load_sram    <= m[23];

      rand_bits(48, r);
      mnt = (phase == 0) ? (r[1:0] == 2'd0) : (r[5:0] == 6'd0);
      img_mounted <= {r[6], mnt, r[10:7]};
      // Empty image about one time in four
      img_size <= (r[12:11] == 2'd0) ? 32'd0 : r[44:13];

      rand_bits(32, r);
      if (phase == 1 && r[3:0] == 4'd0) begin
         ioctl_download <= ~ioctl_download;
      end else if (phase != 1) begin
         ioctl_download <= 1'b0;
      end
      if (!ioctl_download) begin
         ioctl_index <= r[20] ? {r[19:10], 6'd5} : r[19:4];
      end
      motor        <= r[21];
      cas_dout     <= r[22];
      tape_adc     <= r[23];
      tape_adc_act <= r[24];

      rand_bits(32, m);
      sd_sclk <= m[0];
      if (phase == 2) begin
         sd_mosi_core <= m[1];
         card_miso    <= m[2];
         vsd_miso     <= m[3];
      end else begin
         if (m[11:4] == 8'd0) sd_mosi_core <= ~sd_mosi_core;
         if (m[19:12] == 8'd0) card_miso <= ~card_miso;
         if (m[27:20] == 8'd0) vsd_miso <= ~vsd_miso;
      end

      rand_bits(29, r);
      loader_rd <= r[28:0];
      rand_bits(29, r);
      cas_rd <= r[28:0];
      rand_bits(37, r);
      upload_req <= r[36:0];
      rand_bits(37, r);
      cpu_req <= r[36:0];
      rand_bits(10, r);
      sdram_dout  <= r[7:0];
      loader_busy <= r[8];
      upload      <= r[9];
   endtask

   initial begin
      init_inputs();
      repeat (reset_cycles) @(posedge clock_bus);
      rst_n <= 1'b1;
      for (int c = 0; c < num_cycles; c++) begin
         @(posedge clock_bus);
         drive_cycle((c / phase_len) % 4);
      end
      repeat (2) @(posedge clock_bus);
      $display("Checks made: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         if (check_count == 0) begin
            $display("No DUT output was ever compared");
         end
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(clk_period * (reset_cycles + num_cycles + margin_cycles));
      $display("Timeout: the stimulus did not complete in the expected time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
